//--- video_pkg.sv
package video_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    typedef logic [10:0] h_count_t;      // horizontal position
    typedef logic [9:0]  v_count_t;      // vertical position
    typedef logic [21:0] delay_count_t;  // bring-up counter
    typedef logic [7:0]  color_t;        // one colour channel
    typedef logic [4:0]  vs_count_t;     // sensor frame counter
    typedef logic [2:0]  led_t;          // status leds, active low

    // --------------------------------------------------
    // 1280x720 timing
    // --------------------------------------------------
    localparam h_count_t H_ACTIVE = 11'd1280;
    localparam h_count_t H_SYNC   = 11'd40;
    localparam h_count_t H_BP     = 11'd220;
    localparam h_count_t H_FP     = 11'd110;
    localparam h_count_t H_TOTAL  = H_SYNC + H_BP + H_ACTIVE + H_FP;  // 1650

    localparam v_count_t V_ACTIVE = 10'd720;
    localparam v_count_t V_SYNC   = 10'd5;
    localparam v_count_t V_BP     = 10'd20;
    localparam v_count_t V_FP     = 10'd5;
    localparam v_count_t V_TOTAL  = V_SYNC + V_BP + V_ACTIVE + V_FP;  // 750

    // active window edges
    localparam h_count_t H_DE_START = H_SYNC + H_BP;
    localparam h_count_t H_DE_END   = H_DE_START + H_ACTIVE;
    localparam v_count_t V_DE_START = V_SYNC + V_BP;
    localparam v_count_t V_DE_END   = V_DE_START + V_ACTIVE;

    // --------------------------------------------------
    // colour bars
    // --------------------------------------------------
    localparam h_count_t BAR_WIDTH = 11'd160;  // 1280 / 8

    // {r, g, b}, left to right across the screen
    localparam logic [23:0] bar_colors [0:7] = '{
        24'hff_ff_ff,  // white
        24'hff_ff_00,  // yellow
        24'h00_ff_ff,  // cyan
        24'h00_ff_00,  // green
        24'hff_00_ff,  // magenta
        24'hff_00_00,  // red
        24'h00_00_ff,  // blue
        24'h00_00_00   // black
    };

    // rgb565 keeps 5/6/5 msbs, rest zero filled
    localparam color_t RB_565_MASK = 8'hf8;
    localparam color_t G_565_MASK  = 8'hfc;

    // --------------------------------------------------
    // sensor bring-up
    // --------------------------------------------------
    localparam delay_count_t RST_RELEASE_CYCLES = 22'd100_000;
    localparam delay_count_t CFG_START_CYCLES   = 22'd3_000_000;

endpackage

//--- sensor_power_seq.sv
`timescale 1ns/100ps

module sensor_power_seq
(
    input  logic clk,
    input  logic rst_n,
    output logic cmos_rst_n,  // sensor reset, active low
    output logic cfg_start    // sensor may be configured
);

    video_pkg::delay_count_t delay_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            delay_cnt  <= '0;
            cmos_rst_n <= 1'b0;
            cfg_start  <= 1'b0;
        end
        else if (delay_cnt == video_pkg::CFG_START_CYCLES)
        begin
            cfg_start  <= 1'b1;  // counter parks here
        end
        else
        begin
            delay_cnt <= delay_cnt + 1'b1;
            if (delay_cnt == video_pkg::RST_RELEASE_CYCLES)
            begin
                cmos_rst_n <= 1'b1;  // release sensor
            end
        end
    end

endmodule

//--- status_leds.sv
`timescale 1ns/100ps

module status_leds
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmos_vsync,  // sensor clock domain
    input  logic               cmos_rst_n,
    input  logic               cfg_start,
    output video_pkg::led_t    state_led
);

    logic                  vsync_meta;
    logic                  vsync_sync;
    logic                  vsync_prev;
    logic                  vsync_rise;
    video_pkg::vs_count_t  vs_cnt;

    // --------------------------------------------------
    // vsync into clk, then edge count
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vsync_meta <= 1'b0;
            vsync_sync <= 1'b0;
            vsync_prev <= 1'b0;
        end
        else
        begin
            vsync_meta <= cmos_vsync;
            vsync_sync <= vsync_meta;
            vsync_prev <= vsync_sync;
        end
    end

    assign vsync_rise = vsync_sync & ~vsync_prev;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            vs_cnt <= '0;
        else if (vsync_rise)
            vs_cnt <= vs_cnt + 1'b1;  // wraps every 32 frames
    end

    // leds light on low
    assign state_led[2] = ~cfg_start;
    assign state_led[1] = ~vs_cnt[4];  // toggles every 16 frames
    assign state_led[0] = ~cmos_rst_n;

endmodule

//--- video_timing.sv
`timescale 1ns/100ps

module video_timing
(
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 hs,
    output logic                 vs,
    output logic                 de,
    output video_pkg::h_count_t  active_x
);

    video_pkg::h_count_t h_cnt;
    video_pkg::v_count_t v_cnt;
    video_pkg::h_count_t h_nxt;
    video_pkg::v_count_t v_nxt;
    logic                h_wrap;
    logic                de_nxt;

    // --------------------------------------------------
    // frame counters
    // --------------------------------------------------
    assign h_wrap = (h_cnt == video_pkg::H_TOTAL - 1'b1);
    assign h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;

    always_comb
    begin
        v_nxt = v_cnt;
        if (h_wrap)
        begin
            if (v_cnt == video_pkg::V_TOTAL - 1'b1)
                v_nxt = '0;
            else
                v_nxt = v_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
        end
    end

    // outputs decoded from the next count, so they line up with h_cnt
    assign de_nxt = (h_nxt >= video_pkg::H_DE_START) && (h_nxt < video_pkg::H_DE_END) &&
                    (v_nxt >= video_pkg::V_DE_START) && (v_nxt < video_pkg::V_DE_END);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hs       <= 1'b1;  // h=0 sits in sync
            vs       <= 1'b1;  // v=0 sits in sync
            de       <= 1'b0;
            active_x <= '0;
        end
        else
        begin
            hs       <= (h_nxt < video_pkg::H_SYNC);
            vs       <= (v_nxt < video_pkg::V_SYNC);
            de       <= de_nxt;
            active_x <= de_nxt ? h_nxt - video_pkg::H_DE_START : '0;
        end
    end

endmodule

//--- color_bar_gen.sv
`timescale 1ns/100ps

module color_bar_gen
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 de,
    input  video_pkg::h_count_t  active_x,
    output video_pkg::color_t    r,
    output video_pkg::color_t    g,
    output video_pkg::color_t    b
);

    video_pkg::h_count_t bar_num;
    logic [2:0]          bar_idx;
    logic [23:0]         bar_rgb;

    // eight bars of BAR_WIDTH pixels
    assign bar_num = active_x / video_pkg::BAR_WIDTH;
    assign bar_idx = bar_num[2:0];
    assign bar_rgb = video_pkg::bar_colors[bar_idx];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            r <= '0;
            g <= '0;
            b <= '0;
        end
        else if (de)
        begin
            r <= bar_rgb[23:16];
            g <= bar_rgb[15:8];
            b <= bar_rgb[7:0];
        end
        else
        begin
            r <= '0;  // blank between lines
            g <= '0;
            b <= '0;
        end
    end

endmodule

//--- pixel_align.sv
`timescale 1ns/100ps

module pixel_align
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hs,
    input  logic               vs,
    input  logic               de,
    input  logic               quantize,  // rgb565 path on
    input  video_pkg::color_t  r,
    input  video_pkg::color_t  g,
    input  video_pkg::color_t  b,
    output logic               out_hs,
    output logic               out_vs,
    output logic               out_de,
    output video_pkg::color_t  out_r,
    output video_pkg::color_t  out_g,
    output video_pkg::color_t  out_b
);

    logic [1:0]         hs_dly;
    logic [1:0]         vs_dly;
    logic [1:0]         de_dly;
    video_pkg::color_t  rb_mask;
    video_pkg::color_t  g_mask;

    // --------------------------------------------------
    // sync delay, two stages to meet the pixel
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hs_dly <= '0;
            vs_dly <= '0;
            de_dly <= '0;
        end
        else
        begin
            hs_dly <= {hs_dly[0], hs};
            vs_dly <= {vs_dly[0], vs};
            de_dly <= {de_dly[0], de};
        end
    end

    assign out_hs = hs_dly[1];
    assign out_vs = vs_dly[1];
    assign out_de = de_dly[1];

    // low bits dropped as in the 16 bit frame buffer
    assign rb_mask = quantize ? video_pkg::RB_565_MASK : 8'hff;
    assign g_mask  = quantize ? video_pkg::G_565_MASK : 8'hff;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_r <= '0;
            out_g <= '0;
            out_b <= '0;
        end
        else if (de_dly[0])  // pixel and de both at t+1 here
        begin
            out_r <= r & rb_mask;
            out_g <= g & g_mask;
            out_b <= b & rb_mask;
        end
        else
        begin
            out_r <= '0;
            out_g <= '0;
            out_b <= '0;
        end
    end

endmodule

//--- video_top.sv
`timescale 1ns/100ps

module video_top
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmos_vsync,
    input  logic               quantize,
    output logic               cmos_rst_n,
    output video_pkg::led_t    state_led,
    output logic               out_hs,
    output logic               out_vs,
    output logic               out_de,
    output video_pkg::color_t  out_r,
    output video_pkg::color_t  out_g,
    output video_pkg::color_t  out_b
);

    logic                 cfg_start;
    logic                 tim_hs;
    logic                 tim_vs;
    logic                 tim_de;
    video_pkg::h_count_t  tim_x;
    video_pkg::color_t    bar_r;
    video_pkg::color_t    bar_g;
    video_pkg::color_t    bar_b;

    // --------------------------------------------------
    // sensor bring-up and status
    // --------------------------------------------------
    sensor_power_seq u_power_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmos_rst_n (cmos_rst_n),
        .cfg_start  (cfg_start)
    );

    status_leds u_status_leds (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmos_vsync (cmos_vsync),
        .cmos_rst_n (cmos_rst_n),
        .cfg_start  (cfg_start),
        .state_led  (state_led)
    );

    // --------------------------------------------------
    // display path, timing -> bars -> align
    // --------------------------------------------------
    video_timing u_timing (
        .clk      (clk),
        .rst_n    (rst_n),
        .hs       (tim_hs),
        .vs       (tim_vs),
        .de       (tim_de),
        .active_x (tim_x)
    );

    color_bar_gen u_bars (
        .clk      (clk),
        .rst_n    (rst_n),
        .de       (tim_de),
        .active_x (tim_x),
        .r        (bar_r),
        .g        (bar_g),
        .b        (bar_b)
    );

    pixel_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .hs       (tim_hs),
        .vs       (tim_vs),
        .de       (tim_de),
        .quantize (quantize),
        .r        (bar_r),
        .g        (bar_g),
        .b        (bar_b),
        .out_hs   (out_hs),
        .out_vs   (out_vs),
        .out_de   (out_de),
        .out_r    (out_r),
        .out_g    (out_g),
        .out_b    (out_b)
    );

endmodule

//--- video_top_chk.sv
`timescale 1ns/100ps

module video_top_chk
(
    input logic               clk,
    input logic               rst_n,
    input logic               cmos_rst_n,
    input logic               cfg_start,
    input logic               out_hs,
    input logic               out_vs,
    input logic               out_de,
    input video_pkg::color_t  out_r,
    input video_pkg::color_t  out_g,
    input video_pkg::color_t  out_b
);

    // --------------------------------------------------
    // sensor bring-up order
    // --------------------------------------------------
    cfg_after_rst: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_start |-> cmos_rst_n)
        else $error("cfg_start high while sensor still in reset");

    // --------------------------------------------------
    // output stream rules
    // --------------------------------------------------
    de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
        out_de |-> !(out_hs || out_vs))
        else $error("out_de high during a sync pulse");

    blank_is_black: assert property (@(posedge clk) disable iff (!rst_n)
        !out_de |-> (out_r == '0 && out_g == '0 && out_b == '0))
        else $error("pixel not zero outside active video");

endmodule

//--- tb_video_top.sv
`timescale 1ns/100ps

module tb_video_top;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cmos_vsync;
    logic               quantize;
    logic               cmos_rst_n;
    video_pkg::led_t    state_led;
    logic               out_hs;
    logic               out_vs;
    logic               out_de;
    video_pkg::color_t  out_r;
    video_pkg::color_t  out_g;
    video_pkg::color_t  out_b;

    int run_cycles  = int'(video_pkg::CFG_START_CYCLES) + 100_000;
    int timeout_lim = int'(video_pkg::CFG_START_CYCLES) + 101_000;
    int h_de_start  = int'(video_pkg::H_SYNC) + int'(video_pkg::H_BP);
    int v_de_start  = int'(video_pkg::V_SYNC) + int'(video_pkg::V_BP);
    int seed        = 45356;
    int cycle_cnt   = 0;
    int cyc;
    logic run_done      = 1'b0;
    logic fail_reported = 1'b0;
    logic timed_out     = 1'b0;

    // --------------------------------------------------
    // reference model state
    // --------------------------------------------------
    int m_h        = 0;
    int m_v        = 0;
    int bring_cnt  = 0;   // edges since reset release
    int since_rise = 16;  // edges since last vsync rise
    int vsync_left = 8;
    logic vsync_lvl = 1'b0;
    video_pkg::vs_count_t vs_old = '0;
    video_pkg::vs_count_t vs_new = '0;
    logic cur_hs;
    logic cur_vs;
    logic cur_de;
    int   cur_x;
    logic d1_hs = 1'b0;   // timing one cycle back
    logic d1_vs = 1'b0;
    logic d1_de = 1'b0;
    int   d1_x  = 0;
    logic exp_hs = 1'b0;
    logic exp_vs = 1'b0;
    logic exp_de = 1'b0;
    video_pkg::color_t exp_r = '0;
    video_pkg::color_t exp_g = '0;
    video_pkg::color_t exp_b = '0;

    video_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmos_vsync (cmos_vsync),
        .quantize   (quantize),
        .cmos_rst_n (cmos_rst_n),
        .state_led  (state_led),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

    // video_top holds both the sequencer and the align stage
    bind video_top video_top_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmos_rst_n (cmos_rst_n),
        .cfg_start  (cfg_start),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

    always #2 clk = ~clk;  // 4 ns period

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h got %h at cycle %0d", name, exp, act, cycle_cnt);
            fail_reported = 1'b1;
            $display("Regression failed");
            $fatal(1, "output bit does not match the model");
        end
    endtask

    task automatic check_color(input string name, input video_pkg::color_t exp,
                               input video_pkg::color_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h got %h at cycle %0d", name, exp, act, cycle_cnt);
            fail_reported = 1'b1;
            $display("Regression failed");
            $fatal(1, "pixel channel does not match the model");
        end
    endtask

    task automatic check_leds(input video_pkg::led_t exp, input video_pkg::led_t act);
        if (act !== exp)
        begin
            $display("ERR state_led expected %h got %h at cycle %0d", exp, act, cycle_cnt);
            fail_reported = 1'b1;
            $display("Regression failed");
            $fatal(1, "status leds do not match the model");
        end
    endtask

    // --------------------------------------------------
    // model
    // --------------------------------------------------
    task automatic decode_timing();
        logic h_in;
        logic v_in;
        h_in   = (m_h >= h_de_start) && (m_h < h_de_start + int'(video_pkg::H_ACTIVE));
        v_in   = (m_v >= v_de_start) && (m_v < v_de_start + int'(video_pkg::V_ACTIVE));
        cur_hs = (m_h < int'(video_pkg::H_SYNC));
        cur_vs = (m_v < int'(video_pkg::V_SYNC));
        cur_de = h_in && v_in;
        cur_x  = cur_de ? m_h - h_de_start : 0;
    endtask

    task automatic model_step();
        logic [23:0] rgb;
        logic [2:0]  bar;
        logic        q_now;
        q_now  = quantize;  // value before this edge
        exp_hs = d1_hs;
        exp_vs = d1_vs;
        exp_de = d1_de;
        bar    = 3'(d1_x / int'(video_pkg::BAR_WIDTH));
        rgb    = d1_de ? video_pkg::bar_colors[bar] : 24'h0;
        if (q_now)
            rgb = rgb & 24'hf8_fc_f8;  // 5/6/5 msbs kept
        exp_r  = rgb[23:16];
        exp_g  = rgb[15:8];
        exp_b  = rgb[7:0];
        d1_hs  = cur_hs;
        d1_vs  = cur_vs;
        d1_de  = cur_de;
        d1_x   = cur_x;
        m_h    = m_h + 1;
        if (m_h == int'(video_pkg::H_TOTAL))
        begin
            m_h = 0;
            m_v = (m_v == int'(video_pkg::V_TOTAL) - 1) ? 0 : m_v + 1;
        end
        decode_timing();
        bring_cnt = bring_cnt + 1;
        if (since_rise < 16)
            since_rise = since_rise + 1;
    endtask

    task automatic drive_inputs();
        int r;
        if (m_h == 0)
        begin
            r = $random(seed);
            quantize <= r[0];  // new mode each line
        end
        vsync_left = vsync_left - 1;
        if (vsync_left == 0)
        begin
            vsync_lvl  = ~vsync_lvl;
            cmos_vsync <= vsync_lvl;
            vsync_left = 4 + ($unsigned($random(seed)) % 61);
            if (vsync_lvl)
            begin
                vs_old     = vs_new;
                vs_new     = vs_new + 1'b1;
                since_rise = 0;
            end
        end
    endtask

    task automatic check_outputs();
        video_pkg::led_t exp_led;
        logic            rst_exp;
        logic            cfg_exp;
        logic            vs_top;
        rst_exp = (bring_cnt > int'(video_pkg::RST_RELEASE_CYCLES));
        cfg_exp = (bring_cnt > int'(video_pkg::CFG_START_CYCLES));
        vs_top  = (since_rise >= 3) ? vs_new[4] : vs_old[4];  // two sync flops + edge
        exp_led = {~cfg_exp, ~vs_top, ~rst_exp};
        check_bit("cmos_rst_n", rst_exp, cmos_rst_n);
        check_leds(exp_led, state_led);
        check_bit("out_hs", exp_hs, out_hs);
        check_bit("out_vs", exp_vs, out_vs);
        check_bit("out_de", exp_de, out_de);
        check_color("out_r", exp_r, out_r);
        check_color("out_g", exp_g, out_g);
        check_color("out_b", exp_b, out_b);
    endtask

    // --------------------------------------------------
    // stimulus and run control
    // --------------------------------------------------
    initial
    begin
        rst_n      <= 1'b0;
        cmos_vsync <= 1'b0;
        quantize   <= 1'b0;
        decode_timing();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;  // flops still held at this edge
        @(negedge clk);
        check_outputs();  // reset state
        for (cyc = 0; cyc < run_cycles; cyc++)
        begin
            @(posedge clk);
            model_step();
            drive_inputs();
            @(negedge clk);
            check_outputs();
        end
        run_done = 1'b1;
        $display("Regression passed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_lim)
        begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles, run did not complete", timeout_lim);
            $display("Regression failed");
            $fatal(1, "simulation timed out");
        end
    end

    // stopped early by a failed assertion
    final
    begin
        if (!run_done && !fail_reported && !timed_out)
            $display("Regression failed");
    end

endmodule

//--- sim.f
video_pkg.sv
sensor_power_seq.sv
status_leds.sv
video_timing.sv
color_bar_gen.sv
pixel_align.sv
video_top.sv
video_top_chk.sv
tb_video_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing -j 0 -f sim.f --top-module tb_video_top -o tb_video_top \
    && ./obj_dir/tb_video_top; } 2>&1 | tee sim.log

grep -q "Regression failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "result: FAIL, no verdict in log"; exit 1; }
echo "result: PASS"
exit 0
